/* hdl/cpuDefines_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath widths
`define CPU_WORD_W 16
`define CPU_BYTE_W 8
`define CPU_ADDR_W 16

// Stack starts at the top of page zero
`define CPU_SP_RESET 16'h00FF

// T0 and T1 fetch, T2 onward execute
`define CPU_PHASE_N 6

`endif

/* hdl/isaPkg.sv */
`include "cpuDefines_defines.svh"

package isaPkg;

    typedef logic [`CPU_WORD_W-1:0] wordT;
    typedef logic [`CPU_BYTE_W-1:0] byteT;
    typedef logic [1:0]             regIdxT;   // R1..R4 as 0..3

    typedef enum logic [5:0] {
        opBra   = 6'h00,
        opBne   = 6'h01,
        opBeq   = 6'h02,
        opPop   = 6'h03,
        opPsh   = 6'h04,
        opInc   = 6'h05,
        opDec   = 6'h06,
        opLsl   = 6'h07,
        opLsr   = 6'h08,
        opAnd   = 6'h0C,
        opOr    = 6'h0D,
        opNot   = 6'h0E,
        opXor   = 6'h0F,
        opMovh  = 6'h11,
        opLdr   = 6'h12,
        opStr   = 6'h13,
        opMovl  = 6'h14,
        opAdd   = 6'h15,
        opSub   = 6'h17,
        opLdrim = 6'h20
    } opcodeT;

    // Whole instruction word, high byte fetched second
    typedef struct packed {
        opcodeT opcode;   // 15:10
        regIdxT rsel;     // 9:8
        byteT   low;      // immediate, offset or register fields
    } instrT;

    // Low byte of a register-to-register operation
    typedef struct packed {
        regIdxT dst;
        logic   spare1;
        regIdxT src1;
        logic   spare2;
        regIdxT src2;
    } regFieldsT;

endpackage

/* hdl/datapathPkg.sv */
`include "cpuDefines_defines.svh"

package datapathPkg;

    typedef logic [`CPU_ADDR_W-1:0] addrT;

    typedef enum logic [$clog2(`CPU_PHASE_N)-1:0] {
        T0, T1, T2, T3, T4, T5
    } phaseT;

    ////////////////////
    // Block operations

    // Zero code is the idle op in every enum below
    typedef enum logic [2:0] {
        rfHold, rfLoad, rfLoadLow, rfLoadHigh, rfInc, rfDec
    } rfOpT;

    typedef enum logic [2:0] {
        arfHold, arfInc, arfDec, arfLoad, arfAddOffset
    } arfOpT;

    typedef enum logic [1:0] {
        selPc, selSp, selAr
    } arfSelT;

    typedef enum logic [3:0] {
        aluPassA, aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNot, aluLsl, aluLsr
    } aluOpT;

    typedef enum logic [1:0] {
        regInAlu, regInMem, regInImm
    } regInSelT;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic o;
    } flagsT;

    ////////////////////
    // Control bundles

    typedef struct packed {
        rfOpT           op;
        isaPkg::regIdxT dst;
        isaPkg::regIdxT srcA;
        isaPkg::regIdxT srcB;
    } rfCtrlT;

    typedef struct packed {
        arfOpT  op;
        arfSelT target;
        arfSelT addrSel;   // which register drives the memory address
    } arfCtrlT;

    typedef struct packed {
        aluOpT op;
        logic  flagWrite;
    } aluCtrlT;

    typedef struct packed {
        regInSelT regIn;
        logic     byteSel;   // 1 picks the high byte of operand A
    } muxSelT;

    typedef struct packed {
        addrT         addr;
        isaPkg::byteT wdata;
        logic         we;
    } memBusT;

    typedef struct packed {
        rfCtrlT  rf;
        arfCtrlT arf;
        aluCtrlT alu;
        muxSelT  mux;
        logic    memWe;
    } cpuCtrlT;

endpackage

/* hdl/arithmeticLogicUnit.sv */
`timescale 1ns/1ns
`include "cpuDefines_defines.svh"

module arithmeticLogicUnit (
    input  logic                  T,
    input  logic                  rstN,
    input  datapathPkg::aluCtrlT  ctrl,
    input  isaPkg::wordT          a,
    input  isaPkg::wordT          b,
    output isaPkg::wordT          result,
    output datapathPkg::flagsT    flags
);
    import datapathPkg::*;

    localparam int MSB = `CPU_WORD_W - 1;

    logic [`CPU_WORD_W:0] wide;   // extra bit catches carry or borrow
    logic                 carry;
    logic                 overflow;

    always_comb
    begin
        wide     = {1'b0, a};
        carry    = flags.c;
        overflow = flags.o;

        case (ctrl.op)
            aluAdd:
            begin
                wide     = {1'b0, a} + {1'b0, b};
                carry    = wide[`CPU_WORD_W];
                overflow = (a[MSB] == b[MSB]) && (wide[MSB] != a[MSB]);
            end
            aluSub:
            begin
                wide     = {1'b0, a} - {1'b0, b};
                carry    = wide[`CPU_WORD_W];   // borrow
                overflow = (a[MSB] != b[MSB]) && (wide[MSB] != a[MSB]);
            end
            aluAnd: wide = {1'b0, a & b};
            aluOr:  wide = {1'b0, a | b};
            aluXor: wide = {1'b0, a ^ b};
            aluNot: wide = {1'b0, ~a};
            aluLsl:
            begin
                wide  = {1'b0, a << 1};
                carry = a[MSB];
            end
            aluLsr:
            begin
                wide  = {1'b0, a >> 1};
                carry = a[0];
            end
            default: ;   // pass A
        endcase

        result = wide[MSB:0];
    end

    ////////////////////
    // Flag register

    always_ff @(posedge T or negedge rstN)
    begin
        if (!rstN)
        begin
            flags <= '0;
        end
        else if (ctrl.flagWrite)
        begin
            flags.z <= (result == '0);
            flags.c <= carry;
            flags.n <= result[MSB];
            flags.o <= overflow;
        end
    end

endmodule

/* hdl/registerFile.sv */
`timescale 1ns/1ns
`include "cpuDefines_defines.svh"

module registerFile (
    input  logic                 T,
    input  logic                 rstN,
    input  datapathPkg::rfCtrlT  ctrl,
    input  isaPkg::wordT         din,
    output isaPkg::wordT         outA,
    output isaPkg::wordT         outB
);
    import isaPkg::*;
    import datapathPkg::*;

    wordT regs [0:3];   // R1..R4

    assign outA = regs[ctrl.srcA];
    assign outB = regs[ctrl.srcB];

    // Only the selected register moves
    always_ff @(posedge T or negedge rstN)
    begin
        if (!rstN)
        begin
            regs <= '{default: '0};
        end
        else
        begin
            case (ctrl.op)
                rfLoad:     regs[ctrl.dst] <= din;
                rfLoadLow:  regs[ctrl.dst] <= {{`CPU_BYTE_W{1'b0}}, din[`CPU_BYTE_W-1:0]};
                rfLoadHigh:
                begin
                    regs[ctrl.dst] <= {din[`CPU_BYTE_W-1:0], regs[ctrl.dst][`CPU_BYTE_W-1:0]};
                end
                rfInc:      regs[ctrl.dst] <= regs[ctrl.dst] + 1'b1;
                rfDec:      regs[ctrl.dst] <= regs[ctrl.dst] - 1'b1;
                default:    ;
            endcase
        end
    end

endmodule

/* hdl/addressRegisterFile.sv */
`timescale 1ns/1ns
`include "cpuDefines_defines.svh"

module addressRegisterFile (
    input  logic                  T,
    input  logic                  rstN,
    input  datapathPkg::arfCtrlT  ctrl,
    input  isaPkg::wordT          din,
    output datapathPkg::addrT     pc,
    output datapathPkg::addrT     addr
);
    import datapathPkg::*;

    addrT pcReg;
    addrT spReg;
    addrT arReg;
    addrT curVal;
    addrT nextVal;
    addrT offset;

    // Branch offset, sign extended from the low byte
    assign offset = {{(`CPU_ADDR_W-`CPU_BYTE_W){din[`CPU_BYTE_W-1]}}, din[`CPU_BYTE_W-1:0]};

    always_comb
    begin
        case (ctrl.target)
            selSp:   curVal = spReg;
            selAr:   curVal = arReg;
            default: curVal = pcReg;
        endcase

        case (ctrl.op)
            arfInc:       nextVal = curVal + 1'b1;
            arfDec:       nextVal = curVal - 1'b1;
            arfLoad:      nextVal = din;
            arfAddOffset: nextVal = curVal + offset;
            default:      nextVal = curVal;
        endcase
    end

    always_ff @(posedge T or negedge rstN)
    begin
        if (!rstN)
        begin
            pcReg <= '0;
            spReg <= `CPU_SP_RESET;
            arReg <= '0;
        end
        else
        begin
            case (ctrl.target)
                selSp:   spReg <= nextVal;
                selAr:   arReg <= nextVal;
                default: pcReg <= nextVal;
            endcase
        end
    end

    assign pc = pcReg;

    always_comb
    begin
        case (ctrl.addrSel)
            selSp:   addr = spReg;
            selAr:   addr = arReg;
            default: addr = pcReg;   // fetch
        endcase
    end

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/1ns

module controlUnit (
    input  logic                  T,
    input  logic                  rstN,
    input  isaPkg::byteT          memRdata,
    input  logic                  zeroFlag,
    output datapathPkg::cpuCtrlT  ctrl,
    output isaPkg::byteT          imm
);
    import isaPkg::*;
    import datapathPkg::*;

    instrT     ir;
    phaseT     phase;
    logic      lastPhase;
    logic      branchTaken;
    regFieldsT fields;

    function automatic aluOpT aluOpOf(opcodeT op);
        case (op)
            opAdd:   return aluAdd;
            opSub:   return aluSub;
            opAnd:   return aluAnd;
            opOr:    return aluOr;
            opXor:   return aluXor;
            opNot:   return aluNot;
            opLsl:   return aluLsl;
            opLsr:   return aluLsr;
            default: return aluPassA;
        endcase
    endfunction

    assign imm    = ir.low;
    assign fields = regFieldsT'(ir.low);

    assign branchTaken = (ir.opcode == opBra)
                      || (ir.opcode == opBne && !zeroFlag)
                      || (ir.opcode == opBeq && zeroFlag);

    ////////////////////
    // Fetch and sequencing

    always_ff @(posedge T or negedge rstN)
    begin
        if (!rstN)
        begin
            ir <= '0;
        end
        else if (phase == T0)
        begin
            ir[7:0] <= memRdata;   // low byte first
        end
        else if (phase == T1)
        begin
            ir[15:8] <= memRdata;
        end
    end

    always_ff @(posedge T or negedge rstN)
    begin
        if (!rstN)
        begin
            phase <= T0;
        end
        else if (lastPhase)
        begin
            phase <= T0;
        end
        else
        begin
            phase <= phaseT'(phase + 3'd1);
        end
    end

    ////////////////////
    // Decoder

    always_comb
    begin
        ctrl = '0;
        ctrl.arf.addrSel = selPc;
        lastPhase = 1'b0;

        if (phase == T0 || phase == T1)
        begin
            // Byte at PC goes to the IR, PC steps on
            ctrl.arf.op     = arfInc;
            ctrl.arf.target = selPc;
        end
        else
        begin
            case (ir.opcode)
                opBra, opBne, opBeq:
                begin
                    ctrl.arf.target = selPc;
                    if (branchTaken)
                    begin
                        ctrl.arf.op = arfAddOffset;   // relative to the next instruction
                    end
                    lastPhase = 1'b1;
                end

                opMovl, opMovh:
                begin
                    ctrl.rf.op    = (ir.opcode == opMovl) ? rfLoadLow : rfLoadHigh;
                    ctrl.rf.dst   = ir.rsel;
                    ctrl.mux.regIn = regInImm;
                    lastPhase = 1'b1;
                end

                opInc, opDec:
                begin
                    // In place on the destination field, flags untouched
                    ctrl.rf.op  = (ir.opcode == opInc) ? rfInc : rfDec;
                    ctrl.rf.dst = fields.dst;
                    lastPhase = 1'b1;
                end

                opAdd, opSub, opAnd, opOr, opXor, opNot, opLsl, opLsr:
                begin
                    ctrl.rf.op         = rfLoad;
                    ctrl.rf.dst        = fields.dst;
                    ctrl.rf.srcA       = fields.src1;
                    ctrl.rf.srcB       = fields.src2;
                    ctrl.mux.regIn     = regInAlu;
                    ctrl.alu.op        = aluOpOf(ir.opcode);
                    ctrl.alu.flagWrite = ir.rsel[1];
                    lastPhase = 1'b1;
                end

                opPsh:
                begin
                    ctrl.rf.srcA     = ir.rsel;
                    ctrl.arf.addrSel = selSp;
                    ctrl.arf.target  = selSp;
                    ctrl.arf.op      = arfDec;
                    ctrl.memWe       = 1'b1;
                    ctrl.mux.byteSel = (phase == T3);   // low byte, then high
                    lastPhase = (phase == T3);
                end

                opPop:
                begin
                    ctrl.rf.dst      = ir.rsel;
                    ctrl.rf.srcA     = ir.rsel;
                    ctrl.mux.regIn   = regInMem;
                    ctrl.arf.addrSel = selSp;
                    ctrl.arf.target  = selSp;
                    case (phase)
                        T2: ctrl.arf.op = arfInc;
                        T3:
                        begin
                            ctrl.rf.op  = rfLoadHigh;
                            ctrl.arf.op = arfInc;
                        end
                        default:
                        begin
                            // Word load merges with the high byte taken at T3
                            ctrl.rf.op = rfLoad;
                            lastPhase  = 1'b1;
                        end
                    endcase
                end

                opLdr:
                begin
                    ctrl.rf.dst      = ir.rsel;
                    ctrl.mux.regIn   = regInMem;
                    ctrl.arf.addrSel = selAr;
                    ctrl.arf.target  = selAr;
                    if (phase == T2)
                    begin
                        ctrl.rf.op  = rfLoadLow;
                        ctrl.arf.op = arfInc;
                    end
                    else
                    begin
                        ctrl.rf.op = rfLoadHigh;
                        lastPhase  = 1'b1;
                    end
                end

                opStr:
                begin
                    ctrl.rf.srcA     = ir.rsel;
                    ctrl.arf.addrSel = selAr;
                    ctrl.arf.target  = selAr;
                    ctrl.memWe       = 1'b1;
                    if (phase == T2)
                    begin
                        ctrl.arf.op = arfInc;
                    end
                    else
                    begin
                        ctrl.mux.byteSel = 1'b1;
                        lastPhase = 1'b1;
                    end
                end

                opLdrim:
                begin
                    ctrl.rf.dst      = ir.rsel;
                    ctrl.mux.regIn   = regInMem;
                    ctrl.arf.addrSel = selAr;
                    ctrl.arf.target  = selAr;
                    case (phase)
                        T2: ctrl.arf.op = arfLoad;   // AR gets the immediate
                        T3:
                        begin
                            ctrl.rf.op  = rfLoadLow;
                            ctrl.arf.op = arfInc;
                        end
                        default:
                        begin
                            ctrl.rf.op = rfLoadHigh;
                            lastPhase  = 1'b1;
                        end
                    endcase
                end

                default: lastPhase = 1'b1;   // unknown opcode acts as a NOP
            endcase
        end
    end

endmodule

/* hdl/cpuSystem.sv */
`timescale 1ns/1ns
`include "cpuDefines_defines.svh"

module cpuSystem (
    input  logic                 T,
    input  logic                 rstN,
    input  isaPkg::byteT         memRdata,
    output datapathPkg::memBusT  memBus
);
    import isaPkg::*;
    import datapathPkg::*;

    cpuCtrlT ctrl;
    byteT    imm;
    wordT    opA;
    wordT    opB;
    wordT    aluResult;
    flagsT   flags;
    addrT    memAddr;
    wordT    muxAOut;
    wordT    muxBOut;
    byteT    muxCOut;

    ////////////////////
    // Data muxes

    // Memory byte sits under operand A's high byte so POP can finish with a word load
    assign muxAOut = (ctrl.mux.regIn == regInAlu) ? aluResult :
                     (ctrl.mux.regIn == regInMem) ? {opA[`CPU_WORD_W-1:`CPU_BYTE_W], memRdata} :
                                                    {{`CPU_BYTE_W{1'b0}}, imm};

    assign muxBOut = {{`CPU_BYTE_W{1'b0}}, imm};   // AR load value or branch offset

    assign muxCOut = ctrl.mux.byteSel ? opA[`CPU_WORD_W-1:`CPU_BYTE_W] : opA[`CPU_BYTE_W-1:0];

    assign memBus.addr  = memAddr;
    assign memBus.wdata = muxCOut;
    assign memBus.we    = ctrl.memWe;

    controlUnit ctrlUnit (
        .T(T), .rstN(rstN), .memRdata(memRdata), .zeroFlag(flags.z),
        .ctrl(ctrl), .imm(imm)
    );

    registerFile regFile (
        .T(T), .rstN(rstN), .ctrl(ctrl.rf), .din(muxAOut),
        .outA(opA), .outB(opB)
    );

    addressRegisterFile addrRegFile (
        .T(T), .rstN(rstN), .ctrl(ctrl.arf), .din(muxBOut),
        .pc(), .addr(memAddr)
    );

    arithmeticLogicUnit alu (
        .T(T), .rstN(rstN), .ctrl(ctrl.alu), .a(opA), .b(opB),
        .result(aluResult), .flags(flags)
    );

endmodule

/* testbench/cpuSystemTb.sv */
`timescale 1ns/1ns

module cpuSystemTb;
    import isaPkg::*;
    import datapathPkg::*;

    localparam int numProgs  = 5;
    localparam int maxWords  = 24;
    localparam int maxData   = 4;
    localparam int maxWrites = 24;

    localparam regIdxT idxR1 = 2'd0;
    localparam regIdxT idxR2 = 2'd1;
    localparam regIdxT idxR3 = 2'd2;
    localparam regIdxT idxR4 = 2'd3;

    logic   T;
    logic   rstN;
    byteT   memRdata;
    memBusT memBus;
    byteT   mem [0:65535];

    // Program table
    string progName [numProgs];
    wordT  progCode [numProgs][maxWords];
    int    progLen [numProgs];
    int    progSteps [numProgs];   // instructions executed up to the halt
    addrT  haltAddr [numProgs];
    addrT  dataAddr [numProgs][maxData];
    byteT  dataVal [numProgs][maxData];
    int    dataLen [numProgs];
    addrT  expAddr [numProgs][maxWrites];
    byteT  expData [numProgs][maxWrites];
    int    expLen [numProgs];

    addrT arTrack;
    addrT spTrack;
    int   writeCount;
    int   valueErrors = 0;
    int   otherErrors = 0;
    int   cycleLimit;
    logic limitReady = 1'b0;

    cpuSystem DUT (
        .T(T), .rstN(rstN), .memRdata(memRdata), .memBus(memBus)
    );

    assign memRdata = mem[memBus.addr];   // combinational read

    initial
    begin
        T = 1'b0;
        forever #5 T = ~T;
    end

    ////////////////////
    // Encoding and table building

    function automatic wordT encodeImm(opcodeT op, regIdxT rsel, byteT low);
        return {op, rsel, low};
    endfunction

    // RSEL bit 1 carries the flag write
    function automatic wordT encodeRegs(opcodeT op, logic flagWrite, regIdxT dst,
                                        regIdxT src1, regIdxT src2);
        return {op, flagWrite, 1'b0, dst, 1'b0, src1, 1'b0, src2};
    endfunction

    task automatic emit(int p, wordT w);
        progCode[p][progLen[p]] = w;
        progLen[p]++;
    endtask

    task automatic endProgram(int p);
        haltAddr[p] = addrT'(2 * progLen[p]);
        emit(p, encodeImm(opBra, idxR1, 8'hFE));   // branch to itself
    endtask

    task automatic emitOpAndStore(int p, opcodeT op);
        emit(p, encodeRegs(op, 1'b0, idxR3, idxR1, idxR2));
        emit(p, encodeImm(opStr, idxR3, 8'h00));
    endtask

    task automatic preload(int p, addrT a, byteT d);
        dataAddr[p][dataLen[p]] = a;
        dataVal[p][dataLen[p]]  = d;
        dataLen[p]++;
    endtask

    task automatic expectWrite(int p, addrT a, byteT d);
        expAddr[p][expLen[p]] = a;
        expData[p][expLen[p]] = d;
        expLen[p]++;
    endtask

    // STR: low byte at AR, high byte at AR+1, AR left on the high byte
    task automatic expectStore(int p, wordT v);
        expectWrite(p, arTrack, v[7:0]);
        arTrack = arTrack + 16'd1;
        expectWrite(p, arTrack, v[15:8]);
    endtask

    // PSH: low byte at SP, high byte one below
    task automatic expectPush(int p, wordT v);
        expectWrite(p, spTrack, v[7:0]);
        spTrack = spTrack - 16'd1;
        expectWrite(p, spTrack, v[15:8]);
        spTrack = spTrack - 16'd1;
    endtask

    task automatic fillTable();
        wordT a;
        wordT b;
        for (int p = 0; p < numProgs; p++)
        begin
            progLen[p] = 0;
            dataLen[p] = 0;
            expLen[p]  = 0;
        end

        progName[0] = "moveLoadStore";
        emit(0, encodeImm(opMovl, idxR1, 8'h5A));
        emit(0, encodeImm(opMovh, idxR1, 8'hA5));
        emit(0, encodeImm(opLdrim, idxR2, 8'h40));
        emit(0, encodeImm(opStr, idxR1, 8'h00));
        emit(0, encodeImm(opStr, idxR2, 8'h00));
        endProgram(0);
        preload(0, 16'h0040, 8'h34);
        preload(0, 16'h0041, 8'h12);
        arTrack = 16'h0041;   // LDRIM leaves AR on the high byte
        expectStore(0, 16'hA55A);
        expectStore(0, 16'h1234);
        progSteps[0] = 6;

        progName[1] = "aluOps";
        a = 16'hC3A5;
        b = 16'h5F0F;
        emit(1, encodeImm(opLdrim, idxR1, 8'h40));
        emit(1, encodeImm(opLdrim, idxR2, 8'h50));
        emitOpAndStore(1, opAdd);
        emitOpAndStore(1, opSub);
        emitOpAndStore(1, opAnd);
        emitOpAndStore(1, opOr);
        emitOpAndStore(1, opXor);
        emitOpAndStore(1, opNot);
        emitOpAndStore(1, opLsl);
        emitOpAndStore(1, opLsr);
        endProgram(1);
        preload(1, 16'h0040, a[7:0]);
        preload(1, 16'h0041, a[15:8]);
        preload(1, 16'h0050, b[7:0]);
        preload(1, 16'h0051, b[15:8]);
        arTrack = 16'h0051;
        expectStore(1, a + b);
        expectStore(1, a - b);
        expectStore(1, a & b);
        expectStore(1, a | b);
        expectStore(1, a ^ b);
        expectStore(1, ~a);
        expectStore(1, a << 1);
        expectStore(1, a >> 1);
        progSteps[1] = 19;

        progName[2] = "incDecWrap";
        emit(2, encodeImm(opLdrim, idxR4, 8'h60));
        emit(2, encodeImm(opMovl, idxR1, 8'hFF));
        emit(2, encodeImm(opMovh, idxR1, 8'hFF));
        emit(2, encodeRegs(opInc, 1'b0, idxR1, idxR1, idxR1));
        emit(2, encodeImm(opStr, idxR1, 8'h00));
        emit(2, encodeRegs(opDec, 1'b0, idxR1, idxR1, idxR1));
        emit(2, encodeImm(opStr, idxR1, 8'h00));
        emit(2, encodeImm(opMovl, idxR2, 8'hFF));
        emit(2, encodeRegs(opInc, 1'b0, idxR2, idxR2, idxR2));
        emit(2, encodeImm(opStr, idxR2, 8'h00));
        endProgram(2);
        preload(2, 16'h0060, 8'h11);
        preload(2, 16'h0061, 8'h22);
        arTrack = 16'h0061;
        expectStore(2, 16'hFFFF + 16'd1);
        expectStore(2, 16'h0000 - 16'd1);
        expectStore(2, 16'h00FF + 16'd1);   // carry into the high byte
        progSteps[2] = 11;

        progName[3] = "branches";
        emit(3, encodeImm(opLdrim, idxR4, 8'h70));
        emit(3, encodeImm(opMovl, idxR1, 8'h33));
        emit(3, encodeImm(opMovl, idxR2, 8'h33));
        emit(3, encodeRegs(opSub, 1'b1, idxR3, idxR1, idxR2));   // zero, Z set
        emit(3, encodeImm(opBeq, idxR1, 8'h02));                 // taken
        emit(3, encodeImm(opStr, idxR3, 8'h00));                 // skipped
        emit(3, encodeImm(opBne, idxR1, 8'h02));                 // not taken
        emit(3, encodeImm(opStr, idxR2, 8'h00));
        emit(3, encodeImm(opMovl, idxR1, 8'h01));
        emit(3, encodeImm(opMovl, idxR3, 8'h03));
        emit(3, encodeRegs(opInc, 1'b0, idxR2, idxR2, idxR2));   // loop head at 0x14
        emit(3, encodeRegs(opSub, 1'b1, idxR3, idxR3, idxR1));
        emit(3, encodeImm(opBeq, idxR1, 8'h02));
        emit(3, encodeImm(opBra, idxR1, 8'hF8));                 // back to 0x14
        emit(3, encodeImm(opStr, idxR2, 8'h00));
        endProgram(3);
        preload(3, 16'h0070, 8'h99);
        preload(3, 16'h0071, 8'h88);
        arTrack = 16'h0071;
        expectStore(3, 16'h0033);
        expectStore(3, 16'h0033 + 16'd3);   // one increment per pass
        progSteps[3] = 22;

        progName[4] = "pushPop";
        emit(4, encodeImm(opMovl, idxR1, 8'h3C));
        emit(4, encodeImm(opMovh, idxR1, 8'hC7));
        emit(4, encodeImm(opPsh, idxR1, 8'h00));
        emit(4, encodeImm(opPop, idxR3, 8'h00));
        emit(4, encodeImm(opLdrim, idxR4, 8'h80));
        emit(4, encodeImm(opStr, idxR3, 8'h00));
        endProgram(4);
        preload(4, 16'h0080, 8'h5E);
        preload(4, 16'h0081, 8'hE5);
        spTrack = 16'h00FF;
        expectPush(4, 16'hC73C);
        arTrack = 16'h0081;
        expectStore(4, 16'hC73C);
        progSteps[4] = 7;
    endtask

    ////////////////////
    // Checks and memory model

    task automatic checkAddr(string name, addrT expected, addrT actual);
        if (actual !== expected)
        begin
            valueErrors++;
            $display("Error: %s expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkByte(string name, byteT expected, byteT actual);
        if (actual !== expected)
        begin
            valueErrors++;
            $display("Error: %s expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic loadProgram(int p);
        for (int a = 0; a < 65536; a++)
        begin
            mem[a] = byteT'(a[15:8] ^ a[7:0] ^ 8'hA7);   // background, never zero-filled
        end
        for (int i = 0; i < progLen[p]; i++)
        begin
            mem[2 * i]     = progCode[p][i][7:0];   // low byte first
            mem[2 * i + 1] = progCode[p][i][15:8];
        end
        for (int i = 0; i < dataLen[p]; i++)
        begin
            mem[dataAddr[p][i]] = dataVal[p][i];
        end
    endtask

    task automatic serviceWrite(int p);
        string tag;
        if (memBus.we)
        begin
            mem[memBus.addr] = memBus.wdata;
            if (writeCount < expLen[p])
            begin
                tag = $sformatf("%s write %0d", progName[p], writeCount);
                checkAddr({tag, " address"}, expAddr[p][writeCount], memBus.addr);
                checkByte({tag, " data"}, expData[p][writeCount], memBus.wdata);
            end
            else
            begin
                otherErrors++;
                $display("%s: unexpected extra write of %h at %h",
                         progName[p], memBus.wdata, memBus.addr);
            end
            writeCount++;
        end
    endtask

    task automatic runProgram(int p);
        @(posedge T);
        rstN <= 1'b0;
        loadProgram(p);
        writeCount = 0;
        repeat (8) @(posedge T);
        rstN <= 1'b1;
        // Done once the fetch address reaches the closing branch
        do
        begin
            @(negedge T);
            serviceWrite(p);
        end
        while (memBus.addr != haltAddr[p]);
        if (writeCount != expLen[p])
        begin
            otherErrors++;
            $display("%s: expected %0d memory writes but saw %0d",
                     progName[p], expLen[p], writeCount);
        end
    endtask

    ////////////////////
    // Main sequence

    initial
    begin
        rstN = 1'b0;
        fillTable();
        cycleLimit = 100;
        for (int p = 0; p < numProgs; p++)
        begin
            cycleLimit += progSteps[p] * 5 + 10;   // worst case 5 cycles each, plus reset
        end
        limitReady = 1'b1;

        for (int p = 0; p < numProgs; p++)
        begin
            runProgram(p);
        end

        $display("Summary: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (limitReady);
        repeat (cycleLimit) @(posedge T);
        $display("Timeout: the programs did not finish within %0d cycles", cycleLimit);
        $display("Summary: %0d wrong values, %0d other failures", valueErrors, otherErrors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/datapathPkg.sv
hdl/arithmeticLogicUnit.sv
hdl/registerFile.sv
hdl/addressRegisterFile.sv
hdl/controlUnit.sv
hdl/cpuSystem.sv
testbench/cpuSystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the CPU and its testbench with Verilator, run, and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module cpuSystemTb -f build.f -o cpuSim \
    && ./obj_dir/cpuSim | tee sim.log \
    && grep -qx "No errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
